// File: files.f
verilog/vga_pkg.sv
verilog/game_pkg.sv
verilog/vga_timing.sv
verilog/main_menu.sv
verilog/draw_bg.sv
verilog/win_screen.sv
verilog/screen_selector.sv
verilog/game_display_top.sv
tb/game_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the display testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module game_display_tb -o game_display_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/game_display_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0

// File: tb/game_display_tb.sv
`timescale 1ns/1ns
`default_nettype none

module game_display_tb import vga_pkg::*, game_pkg::*; ();

    localparam int CLK_PERIOD     = 20;
    localparam int FRAME_CYCLES   = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int SWITCH_CYCLES  = 40000;             // Random switching before each held screen
    localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 100000;

    logic               clk;
    logic               rst;
    state_t             screen;
    logic               vga_hsync;
    logic               vga_vsync;
    logic [RGB_W-1:0]   vga_rgb;
    logic [COUNT_W-1:0] hcount;
    logic [COUNT_W-1:0] vcount;
    logic               hblnk;
    logic               vblnk;

    int                 low_edges = -1;                // Count of edges with rst low (-1 before any edge)
    state_t             screen_q;
    logic [COUNT_W-1:0] exp_h = '0;
    logic [COUNT_W-1:0] exp_v = '0;

    game_display_top game_display_top_inst (
        .clk(clk),
        .rst(rst),
        .screen(screen),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_rgb(vga_rgb),
        .hcount(hcount),
        .vcount(vcount),
        .hblnk(hblnk),
        .vblnk(vblnk)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_check(input string test, input logic [63:0] expected,
                              input logic [63:0] actual);
        $display("MISMATCH %s expected=0x%0h actual=0x%0h", test, expected, actual);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // {hblnk, vblnk, hsync, vsync} for a position with active-low sync
    function automatic logic [3:0] sync_blank_bits(input logic [COUNT_W-1:0] h,
                                                   input logic [COUNT_W-1:0] v);
        sync_blank_bits = {h >= H_ACTIVE, v >= V_ACTIVE,
                           !(h >= H_SYNC_START && h < H_SYNC_END),
                           !(v >= V_SYNC_START && v < V_SYNC_END)};
    endfunction

    function automatic logic [RGB_W-1:0] pixel_colour(input state_t s,
                                                      input logic [COUNT_W-1:0] h,
                                                      input logic [COUNT_W-1:0] v);
        logic box;
        logic white;
        box   = h >= BOX_X0 && h < BOX_X1 && v >= BOX_Y0 && v < BOX_Y1;
        white = (h < BORDER_W) || (h >= H_ACTIVE - BORDER_W) || (v < BORDER_W) ||
                (v >= V_ACTIVE - BORDER_W) || (h >= MID_X0 && h < MID_X1 && !v[4]);
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return BLACK;
        end
        case (s)
            START:    return box ? MENU_TITLE_RGB : MENU_BG_RGB;
            GAME:     return white ? WHITE : FIELD_RGB;
            PLAYER_1: return box ? P1_RGB : BLACK;
            default:  return box ? P2_RGB : BLACK;
        endcase
    endfunction

    blank_sync_rule: assert property (@(posedge clk) (low_edges >= 3) |->
        {hblnk, vblnk, vga_hsync, vga_vsync} == sync_blank_bits(hcount, vcount))
        else fail_check("blank_sync_rule",
                        int'(sync_blank_bits($sampled(hcount), $sampled(vcount))),
                        int'({$sampled(hblnk), $sampled(vblnk),
                              $sampled(vga_hsync), $sampled(vga_vsync)}));

    // Pins trail the counter by 2 cycles and colour uses screen from the previous edge
    always @(posedge clk) begin
        if (low_edges == 0) begin
            reset_outputs: assert (!(|{hcount, vcount, hblnk, vblnk, vga_hsync, vga_vsync,
                                       vga_rgb}))
                else fail_check("reset_outputs", 0,
                                {hcount, vcount, hblnk, vblnk,
                                 vga_hsync, vga_vsync, vga_rgb});
        end else if (low_edges >= 3) begin
            hcount_step: assert (hcount == exp_h)
                else fail_check("hcount_step", int'(exp_h), int'(hcount));
            vcount_step: assert (vcount == exp_v)
                else fail_check("vcount_step", int'(exp_v), int'(vcount));
            rgb_rule: assert (vga_rgb == pixel_colour(screen_q, exp_h, exp_v))
                else fail_check("rgb_rule", int'(pixel_colour(screen_q, exp_h, exp_v)),
                                int'(vga_rgb));
            if (exp_h == H_TOTAL - 1'b1) begin
                exp_h <= '0;
                exp_v <= (exp_v == V_TOTAL - 1'b1) ? '0 : exp_v + 1'b1;
            end else begin
                exp_h <= exp_h + 1'b1;
            end
        end
        screen_q <= screen;
        if (rst) begin
            low_edges <= 0;
        end else if (low_edges >= 0 && low_edges < 3) begin
            low_edges <= low_edges + 1;
        end
    end

    task automatic switch_screens(input int cycles);
        int         left;
        int         hold;
        logic [1:0] pick;
        left = cycles;
        while (left > 0) begin
            pick = 2'($urandom);
            hold = 1 + int'($urandom % 4000);
            screen <= state_t'(pick);
            repeat (hold) @(posedge clk);
            left = left - hold;
        end
    endtask

    initial begin
        rst    = 1'b1;
        screen = START;
        void'($urandom(32'h5c38b1c8));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            switch_screens(SWITCH_CYCLES);
            screen <= state_t'(i[1:0]);                // Held for a whole frame
            repeat (FRAME_CYCLES) @(posedge clk);
        end
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: verilog/draw_bg.sv
`timescale 1ns/1ns
`default_nettype none

module draw_bg import vga_pkg::*, game_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [COUNT_W-1:0] in_hcount,
    input  logic [COUNT_W-1:0] in_vcount,
    input  logic               in_hblnk,
    input  logic               in_vblnk,
    input  logic               in_hsync,
    input  logic               in_vsync,
    input  logic [RGB_W-1:0]   in_rgb,
    output logic [COUNT_W-1:0] out_hcount,
    output logic [COUNT_W-1:0] out_vcount,
    output logic               out_hblnk,
    output logic               out_vblnk,
    output logic               out_hsync,
    output logic               out_vsync,
    output logic [RGB_W-1:0]   out_rgb
);

    logic             on_border;
    logic             on_mid;
    logic [RGB_W-1:0] rgb_nxt;

    assign on_border = (in_hcount < BORDER_W) || (in_hcount >= H_ACTIVE - BORDER_W) ||
                       (in_vcount < BORDER_W) || (in_vcount >= V_ACTIVE - BORDER_W);

    // Dashes of 16 lines on, 16 off
    assign on_mid = (in_hcount >= MID_X0) && (in_hcount < MID_X1) && !in_vcount[4];

    always_comb begin
        if (in_hblnk || in_vblnk) begin
            rgb_nxt = BLACK;
        end else if (on_border || on_mid) begin
            rgb_nxt = WHITE;
        end else if (in_rgb != BLACK) begin
            rgb_nxt = in_rgb;
        end else begin
            rgb_nxt = FIELD_RGB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= in_hcount;
            out_vcount <= in_vcount;
            out_hblnk  <= in_hblnk;
            out_vblnk  <= in_vblnk;
            out_hsync  <= in_hsync;
            out_vsync  <= in_vsync;
            out_rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/game_display_top.sv
`timescale 1ns/1ns
`default_nettype none

module game_display_top import vga_pkg::*, game_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  state_t             screen,
    output logic               vga_hsync,
    output logic               vga_vsync,
    output logic [RGB_W-1:0]   vga_rgb,
    output logic [COUNT_W-1:0] hcount,           // Position of the pixel on the pins
    output logic [COUNT_W-1:0] vcount,
    output logic               hblnk,
    output logic               vblnk
);

    logic [COUNT_W-1:0] tim_hcount;
    logic [COUNT_W-1:0] tim_vcount;
    logic               tim_hblnk;
    logic               tim_vblnk;
    logic               tim_hsync;
    logic               tim_vsync;

    vga_timing vga_timing_inst (
        .clk(clk),
        .rst(rst),
        .hcount(tim_hcount),
        .vcount(tim_vcount),
        .hblnk(tim_hblnk),
        .vblnk(tim_vblnk),
        .hsync(tim_hsync),
        .vsync(tim_vsync)
    );

    // Renderers start from a black picture
    screen_selector screen_selector_inst (
        .clk(clk),
        .rst(rst),
        .screen(screen),
        .in_hcount(tim_hcount),
        .in_vcount(tim_vcount),
        .in_hblnk(tim_hblnk),
        .in_vblnk(tim_vblnk),
        .in_hsync(tim_hsync),
        .in_vsync(tim_vsync),
        .in_rgb(BLACK),
        .out_hcount(hcount),
        .out_vcount(vcount),
        .out_hblnk(hblnk),
        .out_vblnk(vblnk),
        .out_hsync(vga_hsync),
        .out_vsync(vga_vsync),
        .out_rgb(vga_rgb)
    );

endmodule

`default_nettype wire

// File: verilog/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef enum logic [1:0] {
        START,
        GAME,
        PLAYER_1,
        PLAYER_2
    } state_t;

    // Title and banner box with exclusive upper edges
    localparam logic [vga_pkg::COUNT_W-1:0] BOX_X0 = 11'd192;
    localparam logic [vga_pkg::COUNT_W-1:0] BOX_X1 = 11'd448;
    localparam logic [vga_pkg::COUNT_W-1:0] BOX_Y0 = 11'd160;
    localparam logic [vga_pkg::COUNT_W-1:0] BOX_Y1 = 11'd224;

    // Playing field
    localparam logic [vga_pkg::COUNT_W-1:0] BORDER_W = 11'd8;
    localparam logic [vga_pkg::COUNT_W-1:0] MID_X0   = 11'd316;
    localparam logic [vga_pkg::COUNT_W-1:0] MID_X1   = 11'd324;   // Exclusive

endpackage

`default_nettype wire

// File: verilog/main_menu.sv
`timescale 1ns/1ns
`default_nettype none

module main_menu import vga_pkg::*, game_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [COUNT_W-1:0] in_hcount,
    input  logic [COUNT_W-1:0] in_vcount,
    input  logic               in_hblnk,
    input  logic               in_vblnk,
    input  logic               in_hsync,
    input  logic               in_vsync,
    input  logic [RGB_W-1:0]   in_rgb,
    output logic [COUNT_W-1:0] out_hcount,
    output logic [COUNT_W-1:0] out_vcount,
    output logic               out_hblnk,
    output logic               out_vblnk,
    output logic               out_hsync,
    output logic               out_vsync,
    output logic [RGB_W-1:0]   out_rgb
);

    logic             in_box;
    logic [RGB_W-1:0] rgb_nxt;

    assign in_box = (in_hcount >= BOX_X0) && (in_hcount < BOX_X1) &&
                    (in_vcount >= BOX_Y0) && (in_vcount < BOX_Y1);

    always_comb begin
        if (in_hblnk || in_vblnk) begin
            rgb_nxt = BLACK;
        end else if (in_box) begin
            rgb_nxt = MENU_TITLE_RGB;                // Title box
        end else if (in_rgb != BLACK) begin
            rgb_nxt = in_rgb;                        // Incoming picture shows through
        end else begin
            rgb_nxt = MENU_BG_RGB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= in_hcount;
            out_vcount <= in_vcount;
            out_hblnk  <= in_hblnk;
            out_vblnk  <= in_vblnk;
            out_hsync  <= in_hsync;
            out_vsync  <= in_vsync;
            out_rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/screen_selector.sv
`timescale 1ns/1ns
`default_nettype none

module screen_selector import vga_pkg::*, game_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  state_t             screen,
    input  logic [COUNT_W-1:0] in_hcount,
    input  logic [COUNT_W-1:0] in_vcount,
    input  logic               in_hblnk,
    input  logic               in_vblnk,
    input  logic               in_hsync,
    input  logic               in_vsync,
    input  logic [RGB_W-1:0]   in_rgb,
    output logic [COUNT_W-1:0] out_hcount,
    output logic [COUNT_W-1:0] out_vcount,
    output logic               out_hblnk,
    output logic               out_vblnk,
    output logic               out_hsync,
    output logic               out_vsync,
    output logic [RGB_W-1:0]   out_rgb
);

    // One stream per renderer
    logic [COUNT_W-1:0] start_hcount, game_hcount, p1_hcount, p2_hcount;
    logic [COUNT_W-1:0] start_vcount, game_vcount, p1_vcount, p2_vcount;
    logic               start_hblnk, game_hblnk, p1_hblnk, p2_hblnk;
    logic               start_vblnk, game_vblnk, p1_vblnk, p2_vblnk;
    logic               start_hsync, game_hsync, p1_hsync, p2_hsync;
    logic               start_vsync, game_vsync, p1_vsync, p2_vsync;
    logic [RGB_W-1:0]   start_rgb, game_rgb, p1_rgb, p2_rgb;

    // Selected stream
    logic [COUNT_W-1:0] hcount_nxt;
    logic [COUNT_W-1:0] vcount_nxt;
    logic               hblnk_nxt;
    logic               vblnk_nxt;
    logic               hsync_nxt;
    logic               vsync_nxt;
    logic [RGB_W-1:0]   rgb_nxt;

    main_menu main_menu_inst (
        .clk(clk), .rst(rst),
        .in_hcount(in_hcount), .in_vcount(in_vcount),
        .in_hblnk(in_hblnk), .in_vblnk(in_vblnk),
        .in_hsync(in_hsync), .in_vsync(in_vsync), .in_rgb(in_rgb),
        .out_hcount(start_hcount), .out_vcount(start_vcount),
        .out_hblnk(start_hblnk), .out_vblnk(start_vblnk),
        .out_hsync(start_hsync), .out_vsync(start_vsync), .out_rgb(start_rgb)
    );

    draw_bg draw_bg_inst (
        .clk(clk), .rst(rst),
        .in_hcount(in_hcount), .in_vcount(in_vcount),
        .in_hblnk(in_hblnk), .in_vblnk(in_vblnk),
        .in_hsync(in_hsync), .in_vsync(in_vsync), .in_rgb(in_rgb),
        .out_hcount(game_hcount), .out_vcount(game_vcount),
        .out_hblnk(game_hblnk), .out_vblnk(game_vblnk),
        .out_hsync(game_hsync), .out_vsync(game_vsync), .out_rgb(game_rgb)
    );

    win_screen #(.win_rgb(P1_RGB)) win_p1_inst (
        .clk(clk), .rst(rst),
        .in_hcount(in_hcount), .in_vcount(in_vcount),
        .in_hblnk(in_hblnk), .in_vblnk(in_vblnk),
        .in_hsync(in_hsync), .in_vsync(in_vsync), .in_rgb(in_rgb),
        .out_hcount(p1_hcount), .out_vcount(p1_vcount),
        .out_hblnk(p1_hblnk), .out_vblnk(p1_vblnk),
        .out_hsync(p1_hsync), .out_vsync(p1_vsync), .out_rgb(p1_rgb)
    );

    win_screen #(.win_rgb(P2_RGB)) win_p2_inst (
        .clk(clk), .rst(rst),
        .in_hcount(in_hcount), .in_vcount(in_vcount),
        .in_hblnk(in_hblnk), .in_vblnk(in_vblnk),
        .in_hsync(in_hsync), .in_vsync(in_vsync), .in_rgb(in_rgb),
        .out_hcount(p2_hcount), .out_vcount(p2_vcount),
        .out_hblnk(p2_hblnk), .out_vblnk(p2_vblnk),
        .out_hsync(p2_hsync), .out_vsync(p2_vsync), .out_rgb(p2_rgb)
    );

    // All four encodings are screens
    always_comb begin
        case (screen)
            START: begin
                hcount_nxt = start_hcount;
                vcount_nxt = start_vcount;
                hblnk_nxt  = start_hblnk;
                vblnk_nxt  = start_vblnk;
                hsync_nxt  = start_hsync;
                vsync_nxt  = start_vsync;
                rgb_nxt    = start_rgb;
            end
            GAME: begin
                hcount_nxt = game_hcount;
                vcount_nxt = game_vcount;
                hblnk_nxt  = game_hblnk;
                vblnk_nxt  = game_vblnk;
                hsync_nxt  = game_hsync;
                vsync_nxt  = game_vsync;
                rgb_nxt    = game_rgb;
            end
            PLAYER_1: begin
                hcount_nxt = p1_hcount;
                vcount_nxt = p1_vcount;
                hblnk_nxt  = p1_hblnk;
                vblnk_nxt  = p1_vblnk;
                hsync_nxt  = p1_hsync;
                vsync_nxt  = p1_vsync;
                rgb_nxt    = p1_rgb;
            end
            PLAYER_2: begin
                hcount_nxt = p2_hcount;
                vcount_nxt = p2_vcount;
                hblnk_nxt  = p2_hblnk;
                vblnk_nxt  = p2_vblnk;
                hsync_nxt  = p2_hsync;
                vsync_nxt  = p2_vsync;
                rgb_nxt    = p2_rgb;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= hcount_nxt;
            out_vcount <= vcount_nxt;
            out_hblnk  <= hblnk_nxt;
            out_vblnk  <= vblnk_nxt;
            out_hsync  <= hsync_nxt;
            out_vsync  <= vsync_nxt;
            out_rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // Signal widths
    localparam int COUNT_W = 11;
    localparam int RGB_W   = 12;                    // 4:4:4

    // 640x480 at 60 Hz from a 25 MHz pixel clock
    localparam logic [COUNT_W-1:0] H_ACTIVE     = 11'd640;
    localparam logic [COUNT_W-1:0] H_SYNC_START = 11'd656;
    localparam logic [COUNT_W-1:0] H_SYNC_END   = 11'd752;   // Exclusive
    localparam logic [COUNT_W-1:0] H_TOTAL      = 11'd800;

    localparam logic [COUNT_W-1:0] V_ACTIVE     = 11'd480;
    localparam logic [COUNT_W-1:0] V_SYNC_START = 11'd490;
    localparam logic [COUNT_W-1:0] V_SYNC_END   = 11'd492;   // Exclusive
    localparam logic [COUNT_W-1:0] V_TOTAL      = 11'd525;

    // Palette
    localparam logic [RGB_W-1:0] BLACK          = 12'h000;
    localparam logic [RGB_W-1:0] WHITE          = 12'hFFF;
    localparam logic [RGB_W-1:0] FIELD_RGB      = 12'h060;   // Green
    localparam logic [RGB_W-1:0] MENU_BG_RGB    = 12'h004;   // Dark blue
    localparam logic [RGB_W-1:0] MENU_TITLE_RGB = 12'hFF0;   // Yellow
    localparam logic [RGB_W-1:0] P1_RGB         = 12'hF00;   // Red
    localparam logic [RGB_W-1:0] P2_RGB         = 12'h0FF;   // Cyan

endpackage

`default_nettype wire

// File: verilog/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vga_timing import vga_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic [COUNT_W-1:0] hcount,
    output logic [COUNT_W-1:0] vcount,
    output logic               hblnk,
    output logic               vblnk,
    output logic               hsync,
    output logic               vsync
);

    logic               run;             // Low until the first pixel after reset
    logic [COUNT_W-1:0] hcount_nxt;
    logic [COUNT_W-1:0] vcount_nxt;

    always_comb begin
        hcount_nxt = '0;
        vcount_nxt = '0;
        if (run) begin
            vcount_nxt = vcount;
            if (hcount == H_TOTAL - 1'b1) begin
                if (vcount == V_TOTAL - 1'b1) begin
                    vcount_nxt = '0;
                end else begin
                    vcount_nxt = vcount + 1'b1;
                end
            end else begin
                hcount_nxt = hcount + 1'b1;
            end
        end
    end

    // Blank and sync decoded from the next count so they line up with it
    always_ff @(posedge clk) begin
        if (rst) begin
            run    <= 1'b0;
            hcount <= '0;
            vcount <= '0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else begin
            run    <= 1'b1;
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hblnk  <= (hcount_nxt >= H_ACTIVE);
            vblnk  <= (vcount_nxt >= V_ACTIVE);
            hsync  <= ~((hcount_nxt >= H_SYNC_START) && (hcount_nxt < H_SYNC_END));
            vsync  <= ~((vcount_nxt >= V_SYNC_START) && (vcount_nxt < V_SYNC_END));
        end
    end

endmodule

`default_nettype wire

// File: verilog/win_screen.sv
`timescale 1ns/1ns
`default_nettype none

module win_screen import vga_pkg::*, game_pkg::*; #(
    parameter logic [RGB_W-1:0] win_rgb = P1_RGB    // Banner colour
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [COUNT_W-1:0] in_hcount,
    input  logic [COUNT_W-1:0] in_vcount,
    input  logic               in_hblnk,
    input  logic               in_vblnk,
    input  logic               in_hsync,
    input  logic               in_vsync,
    input  logic [RGB_W-1:0]   in_rgb,
    output logic [COUNT_W-1:0] out_hcount,
    output logic [COUNT_W-1:0] out_vcount,
    output logic               out_hblnk,
    output logic               out_vblnk,
    output logic               out_hsync,
    output logic               out_vsync,
    output logic [RGB_W-1:0]   out_rgb
);

    logic             in_box;
    logic [RGB_W-1:0] rgb_nxt;

    assign in_box = (in_hcount >= BOX_X0) && (in_hcount < BOX_X1) &&
                    (in_vcount >= BOX_Y0) && (in_vcount < BOX_Y1);

    always_comb begin
        if (in_hblnk || in_vblnk) begin
            rgb_nxt = BLACK;
        end else if (in_box) begin
            rgb_nxt = win_rgb;
        end else begin
            rgb_nxt = in_rgb;                        // Banner overlays the incoming picture
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= in_hcount;
            out_vcount <= in_vcount;
            out_hblnk  <= in_hblnk;
            out_vblnk  <= in_vblnk;
            out_hsync  <= in_hsync;
            out_vsync  <= in_vsync;
            out_rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire
